// File: soc_bus_pkg.sv
// Memory map, RAM geometry and Wishbone B4 bus types shared by the SoC bus fabric
package soc_bus_pkg;

  // ==========================================================
  // Bus widths
  // ==========================================================
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned SEL_W      = WORD_W / 8;
  // Byte offset bits inside one word
  localparam int unsigned BYTE_OFS_W = $clog2(SEL_W);

  // ==========================================================
  // Main RAM geometry
  // ==========================================================
  localparam int unsigned LINE_W         = 128;
  localparam int unsigned WORDS_PER_LINE = LINE_W / WORD_W;
  // Word slot select inside a line, address bits 3..2
  localparam int unsigned WORD_IDX_W     = $clog2(WORDS_PER_LINE);
  // Byte offset bits inside one line
  localparam int unsigned LINE_OFS_W     = $clog2(LINE_W / 8);
  localparam int unsigned RAM_SIZE_KB    = 4;
  localparam int unsigned RAM_LINES      = (RAM_SIZE_KB * 1024 * 8) / LINE_W;
  localparam int unsigned RAM_LINE_AW    = $clog2(RAM_LINES);
  // Stages between line read and first-beat ack
  localparam int unsigned RAM_LATENCY    = 4;

  // ==========================================================
  // Memory map
  // ==========================================================
  // Slaves decoded on the top address nibble
  localparam int unsigned DEC_W = 4;
  localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h3000_0000;

  localparam int unsigned NUM_SLAVES = 2;
  localparam int unsigned SLV_IDX_W  = $clog2(NUM_SLAVES);
  localparam int unsigned SLV_RAM    = 0;
  localparam int unsigned SLV_CLINT  = 1;

  // Base per slave index, element 0 is RAM
  localparam logic [NUM_SLAVES-1:0][ADDR_W-1:0] SLV_BASE = {CLINT_BASE, RAM_BASE};

  // CLINT register offsets, 64-bit registers as low word then high word
  localparam int unsigned CLINT_OFS_W = 16;
  localparam logic [CLINT_OFS_W-1:0] CLINT_MSIP_OFS     = 16'h0000;
  localparam logic [CLINT_OFS_W-1:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [CLINT_OFS_W-1:0] CLINT_MTIME_OFS    = 16'hBFF8;
  localparam int unsigned TIME_W = 64;

  // ==========================================================
  // Wishbone types
  // ==========================================================
  // Cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } wb_cti_e;

  // Master to slave, 74 bits
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    wb_cti_e           cti;
  } wb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    logic [WORD_W-1:0] dat;
    logic              ack;
    logic              err;
  } wb_rsp_t;

endpackage

// File: wb_interconnect.sv
// One-to-N Wishbone switch with address decode, response mux and unmapped-access error
`timescale 1ns/10ps

module wb_interconnect (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t m_req_i,
  output soc_bus_pkg::wb_rsp_t m_rsp_o,
  output soc_bus_pkg::wb_req_t s_req_o [soc_bus_pkg::NUM_SLAVES],
  input  soc_bus_pkg::wb_rsp_t s_rsp_i [soc_bus_pkg::NUM_SLAVES]
);

  logic [soc_bus_pkg::DEC_W-1:0]     adr_tag;
  logic                              m_req;
  logic [soc_bus_pkg::SLV_IDX_W-1:0] dec_idx;
  logic                              dec_hit;
  logic [soc_bus_pkg::SLV_IDX_W-1:0] sel_idx;
  logic                              sel_hit;
  logic                              burst_q;
  logic [soc_bus_pkg::SLV_IDX_W-1:0] burst_idx_q;

  // ==========================================================
  // Address decode
  // ==========================================================
  assign adr_tag = m_req_i.adr[soc_bus_pkg::ADDR_W-1 -: soc_bus_pkg::DEC_W];
  assign m_req   = m_req_i.cyc & m_req_i.stb;

  always_comb begin
    dec_idx = '0;
    dec_hit = 1'b0;
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      // Match top nibble against slave base
      if (adr_tag == soc_bus_pkg::SLV_BASE[i][soc_bus_pkg::ADDR_W-1 -: soc_bus_pkg::DEC_W]) begin
        dec_idx = soc_bus_pkg::SLV_IDX_W'(i);
        dec_hit = 1'b1;
      end
    end
  end

  // Mid-burst beats stick to the slave that took the first beat
  assign sel_idx = burst_q ? burst_idx_q : dec_idx;
  assign sel_hit = burst_q | dec_hit;

  // ==========================================================
  // Request fan-out and response mux
  // ==========================================================
  always_comb begin
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      // Shared fields go everywhere
      s_req_o[i] = m_req_i;
      // Handshake only to the selected slave
      s_req_o[i].cyc = m_req_i.cyc & sel_hit & (sel_idx == soc_bus_pkg::SLV_IDX_W'(i));
      s_req_o[i].stb = m_req_i.stb & sel_hit & (sel_idx == soc_bus_pkg::SLV_IDX_W'(i));
    end
  end

  always_comb begin
    m_rsp_o = '0;
    if (sel_hit) begin
      m_rsp_o = s_rsp_i[sel_idx];
    end else begin
      // Unmapped address, same-cycle error
      m_rsp_o.err = m_req;
    end
  end

  // Burst tracking, held from an incrementing ack to end of burst
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      burst_q     <= 1'b0;
      burst_idx_q <= '0;
    end else if (!m_req_i.cyc) begin
      burst_q <= 1'b0;
    end else if (m_rsp_o.ack) begin
      // Another beat follows only after an incrementing beat
      burst_q     <= (m_req_i.cti == soc_bus_pkg::CTI_INCR);
      burst_idx_q <= sel_idx;
    end
  end

endmodule

// File: line_ram.sv
// Cache-line-wide RAM with per-byte write strobes and a registered line read
`timescale 1ns/10ps

module line_ram (
  input  logic                               clk_i,
  input  logic [soc_bus_pkg::RAM_LINE_AW-1:0] addr_i,
  input  logic [soc_bus_pkg::LINE_W-1:0]      wdata_i,
  input  logic [soc_bus_pkg::LINE_W/8-1:0]    wstrb_i,
  input  logic                               rd_en_i,
  output logic [soc_bus_pkg::LINE_W-1:0]      rdata_o
);

  // Line storage
  logic [soc_bus_pkg::LINE_W-1:0] mem_q [soc_bus_pkg::RAM_LINES];

  always_ff @(posedge clk_i) begin
    // Byte-granular write
    for (int b = 0; b < soc_bus_pkg::LINE_W / 8; b++) begin
      if (wstrb_i[b]) begin
        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
    // Line read, output holds until next read
    if (rd_en_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: wb_ram_adapter.sv
// Wishbone slave that maps word accesses onto the line RAM with read latency and burst buffer
`timescale 1ns/10ps

module wb_ram_adapter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  logic                                 req;
  logic                                 rd_req;
  logic                                 wr_req;
  logic                                 is_incr;
  logic [soc_bus_pkg::RAM_LINE_AW-1:0]  line_addr;
  logic [soc_bus_pkg::WORD_IDX_W-1:0]   word_idx;
  logic [soc_bus_pkg::LINE_W-1:0]       wdata_line;
  logic [soc_bus_pkg::LINE_W/8-1:0]     wstrb_line;
  logic [soc_bus_pkg::LINE_W-1:0]       rdata_line;
  logic                                 rd_en;
  logic                                 busy;
  logic                                 pending_q;
  logic [soc_bus_pkg::RAM_LATENCY-1:0]  delay_q;
  logic [soc_bus_pkg::LINE_W-1:0]       buf_q;
  logic                                 buf_valid_q;
  logic                                 first_ack;
  logic                                 beat_ack;
  logic                                 wr_ack;
  logic [soc_bus_pkg::WORD_W-1:0]       rd_word;

  // ==========================================================
  // Request decode
  // ==========================================================
  assign req     = req_i.cyc & req_i.stb;
  assign rd_req  = req & ~req_i.we;
  assign wr_req  = req & req_i.we;
  assign is_incr = (req_i.cti == soc_bus_pkg::CTI_INCR);

  // Line index above the line offset, word slot from bits 3..2
  assign line_addr = req_i.adr[soc_bus_pkg::LINE_OFS_W +: soc_bus_pkg::RAM_LINE_AW];
  assign word_idx  = req_i.adr[soc_bus_pkg::BYTE_OFS_W +: soc_bus_pkg::WORD_IDX_W];

  // Word replicated on every slot, strobes pick the slot
  always_comb begin
    wstrb_line = '0;
    for (int w = 0; w < soc_bus_pkg::WORDS_PER_LINE; w++) begin
      wdata_line[w*soc_bus_pkg::WORD_W +: soc_bus_pkg::WORD_W] = req_i.dat;
    end
    if (wr_req) begin
      wstrb_line[word_idx*soc_bus_pkg::SEL_W +: soc_bus_pkg::SEL_W] = req_i.sel;
    end
  end

  // Read in flight somewhere in the pipeline
  assign busy  = pending_q | (|delay_q);
  // Line read for single access or first burst beat only
  assign rd_en = rd_req & ~buf_valid_q & ~busy;

  line_ram u_line_ram (
    .clk_i   (clk_i),
    .addr_i  (line_addr),
    .wdata_i (wdata_line),
    .wstrb_i (wstrb_line),
    .rd_en_i (rd_en),
    .rdata_o (rdata_line)
  );

  // ==========================================================
  // Latency pipeline
  // ==========================================================
  // Pending stage plus RAM_LATENCY stages, ack on the last one
  assign first_ack = rd_req & delay_q[soc_bus_pkg::RAM_LATENCY-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else if (first_ack || !req_i.cyc) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else begin
      pending_q <= rd_en;
      delay_q   <= {delay_q[soc_bus_pkg::RAM_LATENCY-2:0], pending_q};
    end
  end

  // ==========================================================
  // Burst line buffer
  // ==========================================================
  // Later beats served straight from the buffer
  assign beat_ack = rd_req & buf_valid_q;
  assign wr_ack   = wr_req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (!req_i.cyc || wr_req) begin
      buf_valid_q <= 1'b0;
    end else if (first_ack) begin
      // Kept only when more beats follow
      buf_valid_q <= is_incr;
    end else if (beat_ack && !is_incr) begin
      // End of burst
      buf_valid_q <= 1'b0;
    end
  end

  // Line captured together with first-beat ack
  always_ff @(posedge clk_i) begin
    if (first_ack) begin
      buf_q <= rdata_line;
    end
  end

  // Word select from buffer or fresh RAM line
  always_comb begin
    if (buf_valid_q) begin
      rd_word = buf_q[word_idx*soc_bus_pkg::WORD_W +: soc_bus_pkg::WORD_W];
    end else begin
      rd_word = rdata_line[word_idx*soc_bus_pkg::WORD_W +: soc_bus_pkg::WORD_W];
    end
  end

  assign rsp_o.dat = rd_word;
  assign rsp_o.ack = wr_ack | first_ack | beat_ack;
  assign rsp_o.err = 1'b0;

endmodule

// File: wb_clint.sv
// Core-local interruptor with free-running mtime, mtimecmp, msip and interrupt outputs
`timescale 1ns/10ps

module wb_clint (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t rsp_o,
  output logic                 timer_irq_o,
  output logic                 sw_irq_o
);

  logic                                 access;
  logic [soc_bus_pkg::CLINT_OFS_W-1:0]  ofs;
  logic                                 ack_q;
  logic [soc_bus_pkg::WORD_W-1:0]       dat_q;
  logic [soc_bus_pkg::WORD_W-1:0]       rd_mux;
  logic [soc_bus_pkg::TIME_W-1:0]       mtime_q;
  logic [soc_bus_pkg::TIME_W-1:0]       mtimecmp_q;
  logic                                 msip_q;

  // Byte-select merge of a written word into a register half
  function automatic logic [soc_bus_pkg::WORD_W-1:0] merge_bytes(
    input logic [soc_bus_pkg::WORD_W-1:0] old_w,
    input logic [soc_bus_pkg::WORD_W-1:0] new_w,
    input logic [soc_bus_pkg::SEL_W-1:0]  sel
  );
    logic [soc_bus_pkg::WORD_W-1:0] res;
    res = old_w;
    for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // ==========================================================
  // Access decode
  // ==========================================================
  // Ack phase blocks a second access, so accesses alternate
  assign access = req_i.cyc & req_i.stb & ~ack_q;
  assign ofs    = req_i.adr[soc_bus_pkg::CLINT_OFS_W-1:0];

  always_comb begin
    case (ofs)
      soc_bus_pkg::CLINT_MSIP_OFS:            rd_mux = {31'b0, msip_q};
      soc_bus_pkg::CLINT_MTIMECMP_OFS:        rd_mux = mtimecmp_q[31:0];
      soc_bus_pkg::CLINT_MTIMECMP_OFS + 16'h4: rd_mux = mtimecmp_q[63:32];
      soc_bus_pkg::CLINT_MTIME_OFS:           rd_mux = mtime_q[31:0];
      soc_bus_pkg::CLINT_MTIME_OFS + 16'h4:    rd_mux = mtime_q[63:32];
      default:                                rd_mux = '0;
    endcase
  end

  // ==========================================================
  // Registers
  // ==========================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      mtime_q    <= '0;
      // All ones keeps timer irq low out of reset
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      ack_q   <= access;
      // Free-running time base, read-only from the bus
      mtime_q <= mtime_q + soc_bus_pkg::TIME_W'(1);
      if (access && req_i.we) begin
        case (ofs)
          soc_bus_pkg::CLINT_MSIP_OFS: begin
            if (req_i.sel[0]) begin
              msip_q <= req_i.dat[0];
            end
          end
          soc_bus_pkg::CLINT_MTIMECMP_OFS: begin
            mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_i.dat, req_i.sel);
          end
          soc_bus_pkg::CLINT_MTIMECMP_OFS + 16'h4: begin
            mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_i.dat, req_i.sel);
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read data sampled with the access, presented with ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= rd_mux;
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;

  // Interrupt outputs
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

// File: soc_bus_top.sv
// Bus fabric top joining the Wishbone interconnect, main RAM adapter and CLINT
`timescale 1ns/10ps

module soc_bus_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t wb_req_i,
  output soc_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                 timer_irq_o,
  output logic                 sw_irq_o
);

  // Per-slave request and response
  soc_bus_pkg::wb_req_t slv_req [soc_bus_pkg::NUM_SLAVES];
  soc_bus_pkg::wb_rsp_t slv_rsp [soc_bus_pkg::NUM_SLAVES];

  // ==========================================================
  // Interconnect
  // ==========================================================
  wb_interconnect u_wb_interconnect (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .m_req_i (wb_req_i),
    .m_rsp_o (wb_rsp_o),
    .s_req_o (slv_req),
    .s_rsp_i (slv_rsp)
  );

  // ==========================================================
  // Slaves
  // ==========================================================
  // Main RAM at 0x8000_0000
  wb_ram_adapter u_wb_ram_adapter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (slv_req[soc_bus_pkg::SLV_RAM]),
    .rsp_o  (slv_rsp[soc_bus_pkg::SLV_RAM])
  );

  // CLINT at 0x3000_0000
  wb_clint u_wb_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (slv_req[soc_bus_pkg::SLV_CLINT]),
    .rsp_o       (slv_rsp[soc_bus_pkg::SLV_CLINT]),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

endmodule

// File: tb_soc_bus_top.sv
// Testbench for the SoC bus fabric that checks RAM and CLINT against reference models
`timescale 1ns/10ps

module tb_soc_bus_top;

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 10;
  localparam int ACK_LIMIT   = 20;
  localparam int FILL_LINES  = 4;
  localparam int FILL_WORDS  = FILL_LINES * soc_bus_pkg::WORDS_PER_LINE;
  localparam int N_BURSTS    = 3;
  localparam int TIMER_AHEAD = 24;
  localparam int CLINT_OPS   = 10;
  // Cycle budget of all tests
  localparam int TEST_CYCLES = RST_CYCLES + FILL_WORDS * 2 + 4 * 2
      + FILL_WORDS * (soc_bus_pkg::RAM_LATENCY + 3)
      + N_BURSTS * (soc_bus_pkg::RAM_LATENCY + soc_bus_pkg::WORDS_PER_LINE + 3)
      + CLINT_OPS * 3 + TIMER_AHEAD * 2 + 20;

  logic                 clk_i;
  logic                 rst_ni;
  soc_bus_pkg::wb_req_t wb_req;
  soc_bus_pkg::wb_rsp_t wb_rsp;
  logic                 timer_irq;
  logic                 sw_irq;

  // Reference models
  logic [31:0] ram_model [FILL_WORDS];
  logic [63:0] mtime_model;
  logic [63:0] cmp_model;
  logic        msip_model;
  // mtime seen in the strobe cycle of the last access
  logic [63:0] stb_mtime;
  int          mism_cnt;
  int          proto_cnt;
  int          seed;

  soc_bus_top u_soc_bus_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Time base model counting every clock from zero
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_model <= '0;
    end else begin
      mtime_model <= mtime_model + 64'd1;
    end
  end

  // ============================================================
  // Protocol and interrupt assertions
  // ============================================================
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)) else begin
    proto_cnt++;
    $display("Ack seen without an active cyc and stb");
  end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(wb_rsp.ack && wb_rsp.err)) else begin
    proto_cnt++;
    $display("Ack and err both high in one cycle");
  end

  // Irq high exactly while mtime has reached mtimecmp
  a_timer_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
      timer_irq == (mtime_model >= cmp_model)) else begin
    mism_cnt++;
    $display("Mismatch timer_irq: expected %b, actual %b",
             $sampled(mtime_model >= cmp_model), $sampled(timer_irq));
  end

  a_sw_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
      sw_irq == msip_model) else begin
    mism_cnt++;
    $display("Mismatch sw_irq: expected %b, actual %b", $sampled(msip_model), $sampled(sw_irq));
  end

  // Fill data from the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]};
  endfunction

  // Keep old bytes where sel is clear
  function automatic logic [31:0] merge_sel(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mism_cnt++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ============================================================
  // Wishbone master
  // ============================================================
  // Request back to idle after the last beat
  task automatic bus_release();
    @(posedge clk_i);
    wb_req <= '0;
    @(negedge clk_i);
  endtask

  // Drive on posedge and look at ack and err on negedge
  // Waits counts cycles past the strobe cycle
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input soc_bus_pkg::wb_cti_e cti,
                           input bit hold_cyc, output logic [31:0] rdata,
                           output int waits, output logic got_err);
    soc_bus_pkg::wb_req_t req;
    bit                   done;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    req.sel = sel;
    req.cti = cti;
    waits   = 0;
    done    = 1'b0;
    got_err = 1'b0;
    rdata   = '0;
    @(posedge clk_i);
    wb_req <= req;
    while (!done) begin
      @(negedge clk_i);
      if (waits == 0) begin
        stb_mtime = mtime_model;
      end
      if (wb_rsp.ack || wb_rsp.err) begin
        done    = 1'b1;
        rdata   = wb_rsp.dat;
        got_err = wb_rsp.err;
      end else if (waits >= ACK_LIMIT) begin
        proto_cnt++;
        $display("No ack or err within %0d cycles for address %h", ACK_LIMIT, adr);
        done = 1'b1;
      end else begin
        waits++;
      end
    end
    // Held cycles stay up for the caller
    if (!hold_cyc) begin
      bus_release();
    end
  endtask

  task automatic ram_write(input int word, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] rd;
    int          waits;
    logic        err;
    bus_cycle(1'b1, soc_bus_pkg::RAM_BASE + 32'(word * 4), dat, sel,
              soc_bus_pkg::CTI_CLASSIC, 1'b0, rd, waits, err);
    assert (waits == 0 && !err) else begin
      proto_cnt++;
      $display("RAM write to word %0d not acknowledged in its strobe cycle", word);
    end
    ram_model[word] = merge_sel(ram_model[word], dat, sel);
  endtask

  task automatic ram_read_check(input int word);
    logic [31:0] rd;
    int          waits;
    logic        err;
    bus_cycle(1'b0, soc_bus_pkg::RAM_BASE + 32'(word * 4), '0, 4'hF,
              soc_bus_pkg::CTI_CLASSIC, 1'b0, rd, waits, err);
    assert (waits == soc_bus_pkg::RAM_LATENCY + 1 && !err) else begin
      proto_cnt++;
      $display("RAM read of word %0d answered after %0d cycles, err %b", word, waits, err);
    end
    check_value($sformatf("ram_read word %0d", word), ram_model[word], rd);
  endtask

  // Four beats over one whole line with end-of-burst on the last
  task automatic burst_read_check(input int line);
    logic [31:0]          rd;
    int                   waits;
    logic                 err;
    int                   word;
    int                   exp_wait;
    soc_bus_pkg::wb_cti_e cti;
    for (int b = 0; b < soc_bus_pkg::WORDS_PER_LINE; b++) begin
      word     = line * soc_bus_pkg::WORDS_PER_LINE + b;
      cti      = (b == soc_bus_pkg::WORDS_PER_LINE - 1) ? soc_bus_pkg::CTI_EOB
                                                        : soc_bus_pkg::CTI_INCR;
      exp_wait = (b == 0) ? soc_bus_pkg::RAM_LATENCY + 1 : 0;
      bus_cycle(1'b0, soc_bus_pkg::RAM_BASE + 32'(word * 4), '0, 4'hF, cti,
                b != soc_bus_pkg::WORDS_PER_LINE - 1, rd, waits, err);
      assert (waits == exp_wait && !err) else begin
        proto_cnt++;
        $display("Burst beat %0d of line %0d answered after %0d cycles, err %b",
                 b, line, waits, err);
      end
      check_value($sformatf("burst line %0d beat %0d", line, b), ram_model[word], rd);
    end
  endtask

  task automatic clint_access(input logic we, input logic [15:0] ofs, input logic [31:0] dat,
                              input logic [3:0] sel, input bit hold_cyc,
                              output logic [31:0] rd);
    int   waits;
    logic err;
    bus_cycle(we, soc_bus_pkg::CLINT_BASE + 32'(ofs), dat, sel,
              soc_bus_pkg::CTI_CLASSIC, hold_cyc, rd, waits, err);
    assert (waits == 1 && !err) else begin
      proto_cnt++;
      $display("CLINT access at offset %h acknowledged after %0d cycles", ofs, waits);
    end
  endtask

  // Writes also move the mtimecmp and msip models
  task automatic clint_write(input logic [15:0] ofs, input logic [31:0] dat,
                             input logic [3:0] sel);
    logic [31:0] rd;
    clint_access(1'b1, ofs, dat, sel, 1'b1, rd);
    // Register took the write on the edge before the ack cycle
    if (ofs == soc_bus_pkg::CLINT_MTIMECMP_OFS) begin
      cmp_model[31:0] = merge_sel(cmp_model[31:0], dat, sel);
    end else if (ofs == soc_bus_pkg::CLINT_MTIMECMP_OFS + 16'h4) begin
      cmp_model[63:32] = merge_sel(cmp_model[63:32], dat, sel);
    end else if (ofs == soc_bus_pkg::CLINT_MSIP_OFS && sel[0]) begin
      msip_model = dat[0];
    end
    bus_release();
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    logic [31:0] rd;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [63:0] target;
    int          waits;
    logic        err;
    int          guard;
    seed       = 80349;
    mism_cnt   = 0;
    proto_cnt  = 0;
    rst_ni     = 1'b0;
    wb_req     = '0;
    cmp_model  = '1;
    msip_model = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!wb_rsp.ack && !wb_rsp.err && !timer_irq && !sw_irq) else begin
      proto_cnt++;
      $display("Outputs not idle after reset");
    end

    // Fill, then partial writes, then read every word back
    for (int w = 0; w < FILL_WORDS; w++) begin
      ram_write(w, fill_word(soc_bus_pkg::RAM_BASE + 32'(w * 4)), 4'hF);
    end
    ram_write(5, 32'hDEAD_BEEF, 4'b0001);
    ram_write(6, 32'h1234_5678, 4'b0110);
    ram_write(9, 32'hCAFE_F00D, 4'b1000);
    ram_write(10, 32'h0BAD_C0DE, 4'b1100);
    for (int w = 0; w < FILL_WORDS; w++) begin
      ram_read_check(w);
    end
    repeat (N_BURSTS) begin
      burst_read_check(($random(seed) & 32'h7FFF_FFFF) % FILL_LINES);
    end

    // mtime reads against the cycle model
    clint_access(1'b0, soc_bus_pkg::CLINT_MTIME_OFS, '0, 4'hF, 1'b0, t0);
    check_value("mtime_first", stb_mtime[31:0], t0);
    clint_access(1'b0, soc_bus_pkg::CLINT_MTIME_OFS, '0, 4'hF, 1'b0, t1);
    check_value("mtime_second", stb_mtime[31:0], t1);
    assert (t1 > t0) else begin
      proto_cnt++;
      $display("mtime did not advance between two reads");
    end

    // High half first so the compare never drops below mtime early
    target = mtime_model + 64'(TIMER_AHEAD);
    clint_write(soc_bus_pkg::CLINT_MTIMECMP_OFS + 16'h4, 32'h0, 4'hF);
    clint_write(soc_bus_pkg::CLINT_MTIMECMP_OFS, target[31:0], 4'hF);
    guard = 0;
    while (!timer_irq && guard < TIMER_AHEAD * 2) begin
      @(negedge clk_i);
      guard++;
    end
    assert (timer_irq) else begin
      proto_cnt++;
      $display("Timer interrupt never rose after mtimecmp was reached");
    end
    repeat (5) @(negedge clk_i);
    check_value("timer_irq_hold", 32'd1, 32'(timer_irq));
    clint_write(soc_bus_pkg::CLINT_MTIMECMP_OFS + 16'h4, 32'hFFFF_FFFF, 4'hF);
    check_value("timer_irq_clear", 32'd0, 32'(timer_irq));

    // Software interrupt set and clear
    clint_write(soc_bus_pkg::CLINT_MSIP_OFS, 32'h1, 4'h1);
    check_value("sw_irq_set", 32'd1, 32'(sw_irq));
    clint_access(1'b0, soc_bus_pkg::CLINT_MSIP_OFS, '0, 4'hF, 1'b0, rd);
    check_value("msip_read_one", 32'd1, rd);
    clint_write(soc_bus_pkg::CLINT_MSIP_OFS, 32'h0, 4'h1);
    check_value("sw_irq_clear", 32'd0, 32'(sw_irq));
    clint_access(1'b0, soc_bus_pkg::CLINT_MSIP_OFS, '0, 4'hF, 1'b0, rd);
    check_value("msip_read_zero", 32'd0, rd);

    // Unmapped window
    bus_cycle(1'b0, 32'h5000_0000, '0, 4'hF, soc_bus_pkg::CTI_CLASSIC, 1'b0, rd, waits, err);
    assert (err && waits == 0) else begin
      proto_cnt++;
      $display("Unmapped access did not get a same-cycle error");
    end

    @(posedge clk_i);
    $display("Error counts: %0d mismatches, %0d protocol errors", mism_cnt, proto_cnt);
    if (mism_cnt == 0 && proto_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog at twice the cycle budget
  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, test did not complete", TEST_CYCLES * 2);
    $display("Error counts: %0d mismatches, %0d protocol errors", mism_cnt, proto_cnt);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: soc_bus_top.f
soc_bus_pkg.sv
wb_interconnect.sv
line_ram.sv
wb_ram_adapter.sv
wb_clint.sv
soc_bus_top.sv
tb_soc_bus_top.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_bus_pkg.sv
  - wb_interconnect.sv
  - line_ram.sv
  - wb_ram_adapter.sv
  - wb_clint.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus_top.sv
